// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLAGS     ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== source/address_translator.sv ====
`timescale 1ns/1ps

module address_translator import lsu_pkg::*; #(
  parameter int MAP_ENTRIES = 4
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           lookup_valid,
  input  logic [XLEN-1:0]                vaddr,
  output logic                           hit,
  output logic                           fault,
  output logic [XLEN-1:0]                paddr,
  input  logic                           map_write,
  input  logic [$clog2(MAP_ENTRIES)-1:0] map_index,
  input  logic [XLEN-PAGE_BITS-1:0]      map_ppn,
  input  logic                           map_enable
);

  localparam int INDEX_BITS = $clog2(MAP_ENTRIES);

  logic [MAP_ENTRIES-1:0]      entry_valid;
  logic [XLEN-PAGE_BITS-1:0]   entry_ppn [MAP_ENTRIES];
  logic [INDEX_BITS-1:0]       index;

  assign index = vaddr[PAGE_BITS +: INDEX_BITS];  // Low VPN bits

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      hit         <= 1'b0;
      fault       <= 1'b0;
    end else begin
      if (map_write) entry_valid[map_index] <= map_enable;
      // One answer per lookup, then idle until the next one
      if (lookup_valid && !(hit || fault)) begin
        hit   <= entry_valid[index];
        fault <= !entry_valid[index];
      end else begin
        hit   <= 1'b0;
        fault <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (map_write) entry_ppn[map_index] <= map_ppn;
    if (lookup_valid) paddr <= {entry_ppn[index], vaddr[PAGE_BITS-1:0]};
  end

  // An answer is exclusive and always follows a lookup
  a_answer: assert property (@(posedge clock) disable iff (reset)
    hit || fault |-> !(hit && fault) && $past(lookup_valid));

endmodule

// ==== source/axi_if.sv ====
`timescale 1ns/1ps

interface axi_if import lsu_pkg::*; (
  input logic clock
);

  // Read address and read data
  logic                     arvalid, arready;
  logic [XLEN-1:0]          araddr;
  logic [AXI_ID_WIDTH-1:0]  arid;
  logic [AXI_LEN_WIDTH-1:0] arlen;
  logic [2:0]               arsize;
  logic [1:0]               arburst;
  logic                     rvalid, rready;
  logic [XLEN-1:0]          rdata;
  logic [1:0]               rresp;
  logic                     rlast;

  // Write address, write data and response
  logic                     awvalid, awready;
  logic [XLEN-1:0]          awaddr;
  logic [AXI_ID_WIDTH-1:0]  awid;
  logic [AXI_LEN_WIDTH-1:0] awlen;
  logic [2:0]               awsize;
  logic [1:0]               awburst;
  logic                     wvalid, wready;
  logic [XLEN-1:0]          wdata;
  logic [XLEN/8-1:0]        wstrb;
  logic                     wlast;
  logic                     bvalid, bready;
  logic [1:0]               bresp;

  modport out (
    input  clock,
    output arvalid, araddr, arid, arlen, arsize, arburst, rready,
    output awvalid, awaddr, awid, awlen, awsize, awburst,
    output wvalid, wdata, wstrb, wlast, bready,
    input  arready, rvalid, rdata, rresp, rlast,
    input  awready, wready, bvalid, bresp
  );

  modport in (
    input  clock,
    input  arvalid, araddr, arid, arlen, arsize, arburst, rready,
    input  awvalid, awaddr, awid, awlen, awsize, awburst,
    input  wvalid, wdata, wstrb, wlast, bready,
    output arready, rvalid, rdata, rresp, rlast,
    output awready, wready, bvalid, bresp
  );

endinterface

// ==== source/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram import lsu_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input logic clock,
  input logic reset,
  axi_if.in   bus_r,
  axi_if.in   bus_w
);

  localparam int WORD_BITS = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];

  // ####################################################################
  // Read side
  // ####################################################################

  logic            rvalid_q;
  logic [XLEN-1:0] rdata_q;

  assign bus_r.arready = !rvalid_q;  // Idle
  assign bus_r.rvalid  = rvalid_q;
  assign bus_r.rdata   = rdata_q;
  assign bus_r.rresp   = AXI_RESP_OKAY;
  assign bus_r.rlast   = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
    end else if (bus_r.arvalid && bus_r.arready) begin
      rvalid_q <= 1'b1;
    end else if (bus_r.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (bus_r.arvalid && bus_r.arready) rdata_q <= mem[bus_r.araddr[2 +: WORD_BITS]];
  end

  // ####################################################################
  // Write side
  // ####################################################################

  logic                 aw_held, w_held, bvalid_q;
  logic [WORD_BITS-1:0] waddr_q;
  logic [XLEN-1:0]      wdata_q;
  logic [XLEN/8-1:0]    wstrb_q;

  // Halves stay held until the response is taken
  assign bus_w.awready = !aw_held;
  assign bus_w.wready  = !w_held;
  assign bus_w.bvalid  = bvalid_q;
  assign bus_w.bresp   = AXI_RESP_OKAY;

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
    end else if (bvalid_q && bus_w.bready) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      if (bus_w.awvalid && bus_w.awready) aw_held <= 1'b1;
      if (bus_w.wvalid && bus_w.wready) w_held <= 1'b1;
      if (aw_held && w_held) bvalid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (bus_w.awvalid && bus_w.awready) waddr_q <= bus_w.awaddr[2 +: WORD_BITS];
    if (bus_w.wvalid && bus_w.wready) begin
      wdata_q <= bus_w.wdata;
      wstrb_q <= bus_w.wstrb;
    end
    if (aw_held && w_held && !bvalid_q) begin
      for (int i = 0; i < XLEN/8; i++) begin
        if (wstrb_q[i]) mem[waddr_q][8*i +: 8] <= wdata_q[8*i +: 8];
      end
    end
  end

  // Unused channels on each port
  assign bus_r.awready = 1'b0;
  assign bus_r.wready  = 1'b0;
  assign bus_r.bvalid  = 1'b0;
  assign bus_r.bresp   = AXI_RESP_OKAY;
  assign bus_w.arready = 1'b0;
  assign bus_w.rvalid  = 1'b0;
  assign bus_w.rdata   = '0;
  assign bus_w.rresp   = AXI_RESP_OKAY;
  assign bus_w.rlast   = 1'b0;

  a_single_beat_r: assert property (@(posedge clock) disable iff (reset)
    bus_r.arvalid && bus_r.arready |-> bus_r.arlen == '0);
  a_single_beat_w: assert property (@(posedge clock) disable iff (reset)
    bus_w.awvalid && bus_w.awready |-> bus_w.awlen == '0);

endmodule

// ==== source/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit import lsu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  axi_if.out              mem_r,
  axi_if.out              mem_w,
  output logic            lookup_valid,
  output logic [XLEN-1:0] vaddr,
  input  logic            hit,
  input  logic            fault,
  input  logic [XLEN-1:0] paddr,
  output logic            req_ready,
  input  logic            req_valid,
  input  mem_op_t         req_op,
  input  logic [XLEN-1:0] req_addr,
  input  logic [XLEN-1:0] req_wdata,
  input  logic            resp_ready,
  output logic            resp_valid,
  output logic [XLEN-1:0] resp_rdata,
  output logic            resp_fault
);

  typedef enum logic [3:0] {
    ST_IDLE, ST_TRANSLATE,
    ST_LOAD_REQ, ST_LOAD_RESP,
    ST_STORE_REQ, ST_STORE_ADDR, ST_STORE_DATA, ST_STORE_RESP,
    ST_HOLD
  } state_t;

  state_t state, state_next;

  mem_op_t           op;
  logic [XLEN-1:0]   addr;  // virtual, then physical after the lookup
  logic [XLEN-1:0]   wdata;
  logic [XLEN-1:0]   result;
  logic              fault_q;
  logic              accept;
  logic [XLEN-1:0]   rdata_shifted;
  logic [XLEN-1:0]   load_data;
  logic [XLEN/8-1:0] strb_base;

  assign req_ready = (state == ST_IDLE) || (state == ST_HOLD && resp_ready);
  assign accept    = req_valid && req_ready;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:      if (req_valid) state_next = ST_TRANSLATE;
      ST_TRANSLATE: begin
        if (fault) state_next = ST_HOLD;  // No bus access
        else if (hit) state_next = op.is_load ? ST_LOAD_REQ : ST_STORE_REQ;
      end
      ST_LOAD_REQ:  if (mem_r.arready) state_next = ST_LOAD_RESP;
      ST_LOAD_RESP: if (mem_r.rvalid) state_next = ST_HOLD;
      ST_STORE_REQ: begin
        if (mem_w.awready && mem_w.wready) state_next = ST_STORE_RESP;
        else if (mem_w.awready) state_next = ST_STORE_DATA;
        else if (mem_w.wready) state_next = ST_STORE_ADDR;
      end
      ST_STORE_ADDR: if (mem_w.awready) state_next = ST_STORE_RESP;
      ST_STORE_DATA: if (mem_w.wready) state_next = ST_STORE_RESP;
      ST_STORE_RESP: if (mem_w.bvalid) state_next = ST_HOLD;
      ST_HOLD:      if (resp_ready) state_next = req_valid ? ST_TRANSLATE : ST_IDLE;
      default:      state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= ST_IDLE;
      fault_q <= 1'b0;
    end else begin
      state <= state_next;
      if (accept) fault_q <= 1'b0;
      else if (state == ST_TRANSLATE && fault) fault_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      op    <= req_op;
      addr  <= req_addr;
      wdata <= req_wdata;
    end else if (state == ST_TRANSLATE && hit) begin
      addr <= paddr;
    end
    if (state == ST_LOAD_RESP && mem_r.rvalid) result <= load_data;
    else if (state == ST_STORE_RESP && mem_w.bvalid) result <= '0;
    else if (state == ST_TRANSLATE && fault) result <= '0;
  end

  assign lookup_valid = state == ST_TRANSLATE;
  assign vaddr        = addr;
  assign resp_valid   = state == ST_HOLD;
  assign resp_rdata   = result;
  assign resp_fault   = fault_q;

  // ####################################################################
  // Load path
  // ####################################################################

  assign mem_r.arvalid = state == ST_LOAD_REQ;
  assign mem_r.araddr  = addr;
  assign mem_r.arid    = '0;
  assign mem_r.arlen   = '0;  // Single beat
  assign mem_r.arsize  = {1'b0, op.size};
  assign mem_r.arburst = AXI_BURST_INCR;
  assign mem_r.rready  = state == ST_LOAD_RESP;

  always_comb begin
    rdata_shifted = mem_r.rdata >> {addr[1:0], 3'b000};
    case (op.size)
      SIZE_BYTE: load_data = {{(XLEN-8){op.is_signed & rdata_shifted[7]}},
                              rdata_shifted[7:0]};
      SIZE_HALF: load_data = {{(XLEN-16){op.is_signed & rdata_shifted[15]}},
                              rdata_shifted[15:0]};
      default:   load_data = rdata_shifted;
    endcase
  end

  // Write channels of the read port stay idle
  assign mem_r.awvalid = 1'b0;
  assign mem_r.awaddr  = '0;
  assign mem_r.awid    = '0;
  assign mem_r.awlen   = '0;
  assign mem_r.awsize  = '0;
  assign mem_r.awburst = '0;
  assign mem_r.wvalid  = 1'b0;
  assign mem_r.wdata   = '0;
  assign mem_r.wstrb   = '0;
  assign mem_r.wlast   = 1'b0;
  assign mem_r.bready  = 1'b0;

  // ####################################################################
  // Store path
  // ####################################################################

  always_comb begin
    case (op.size)
      SIZE_BYTE: strb_base = 4'b0001;
      SIZE_HALF: strb_base = 4'b0011;
      SIZE_WORD: strb_base = 4'b1111;
      default:   strb_base = 4'b0000;
    endcase
  end

  assign mem_w.awvalid = state == ST_STORE_REQ || state == ST_STORE_ADDR;
  assign mem_w.awaddr  = addr;
  assign mem_w.awid    = '0;
  assign mem_w.awlen   = '0;
  assign mem_w.awsize  = {1'b0, op.size};
  assign mem_w.awburst = AXI_BURST_INCR;
  assign mem_w.wvalid  = state == ST_STORE_REQ || state == ST_STORE_DATA;
  assign mem_w.wdata   = wdata << {addr[1:0], 3'b000};  // Lane steering
  assign mem_w.wstrb   = strb_base << addr[1:0];
  assign mem_w.wlast   = 1'b1;
  assign mem_w.bready  = state == ST_STORE_RESP;

  assign mem_w.arvalid = 1'b0;
  assign mem_w.araddr  = '0;
  assign mem_w.arid    = '0;
  assign mem_w.arlen   = '0;
  assign mem_w.arsize  = '0;
  assign mem_w.arburst = '0;
  assign mem_w.rready  = 1'b0;

  // Valids hold with stable payload until accepted
  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    mem_r.arvalid && !mem_r.arready |=> mem_r.arvalid && $stable(mem_r.araddr));
  a_aw_hold: assert property (@(posedge clock) disable iff (reset)
    mem_w.awvalid && !mem_w.awready |=> mem_w.awvalid && $stable(mem_w.awaddr));
  a_w_hold: assert property (@(posedge clock) disable iff (reset)
    mem_w.wvalid && !mem_w.wready |=> mem_w.wvalid && $stable(mem_w.wdata));

  // A fault result carries no data and the bus stays quiet
  a_fault_no_bus: assert property (@(posedge clock) disable iff (reset)
    state == ST_TRANSLATE && fault |=> resp_valid && resp_fault && resp_rdata == '0
      && !mem_r.arvalid && !mem_w.awvalid && !mem_w.wvalid);

endmodule

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

  // ####################################################################
  // Data path widths
  // ####################################################################

  localparam int XLEN      = 32;
  localparam int PAGE_BITS = 12;  // 4 KiB pages

  // ####################################################################
  // Bus constants
  // ####################################################################

  localparam int AXI_ID_WIDTH  = 4;
  localparam int AXI_LEN_WIDTH = 8;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  // ####################################################################
  // Operation encoding
  // ####################################################################

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_t;

  // Bit 3 load, bit 2 signed, bits 1:0 size
  typedef struct packed {
    logic         is_load;
    logic         is_signed;
    access_size_t size;
  } mem_op_t;

endpackage

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int MAP_ENTRIES = 4,
  parameter int MEM_WORDS   = 1024
) (
  input  logic                           clock,
  input  logic                           reset,
  output logic                           req_ready,
  input  logic                           req_valid,
  input  mem_op_t                        req_op,
  input  logic [XLEN-1:0]                req_addr,
  input  logic [XLEN-1:0]                req_wdata,
  input  logic                           resp_ready,
  output logic                           resp_valid,
  output logic [XLEN-1:0]                resp_rdata,
  output logic                           resp_fault,
  input  logic                           map_write,
  input  logic [$clog2(MAP_ENTRIES)-1:0] map_index,
  input  logic [XLEN-PAGE_BITS-1:0]      map_ppn,
  input  logic                           map_enable
);

  logic            lookup_valid, hit, fault;
  logic [XLEN-1:0] vaddr, paddr;

  axi_if mem_r (.clock(clock));
  axi_if mem_w (.clock(clock));

  load_store_unit lsu (
    .clock, .reset, .mem_r, .mem_w, .lookup_valid, .vaddr, .hit, .fault, .paddr,
    .req_ready, .req_valid, .req_op, .req_addr, .req_wdata,
    .resp_ready, .resp_valid, .resp_rdata, .resp_fault
  );

  address_translator #(.MAP_ENTRIES(MAP_ENTRIES)) mmu (
    .clock, .reset, .lookup_valid, .vaddr, .hit, .fault, .paddr,
    .map_write, .map_index, .map_ppn, .map_enable
  );

  axi_sram #(.MEM_WORDS(MEM_WORDS)) sram (
    .clock, .reset, .bus_r(mem_r), .bus_w(mem_w)
  );

endmodule

// ==== src.f ====
source/lsu_pkg.sv
source/axi_if.sv
source/address_translator.sv
source/axi_sram.sv
source/load_store_unit.sv
source/lsu_top.sv
test/lsu_tb.sv

// ==== test/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*;;

  localparam int MAP_ENTRIES = 4;
  localparam int MEM_WORDS   = 1024;
  localparam int MEM_BYTES   = MEM_WORDS * 4;  // Physical pages alias in the SRAM
  localparam int TIMEOUT     = 200;

  logic                      clock, reset;
  logic                      req_ready, req_valid, resp_ready, resp_valid, resp_fault;
  mem_op_t                   req_op;
  logic [XLEN-1:0]           req_addr, req_wdata, resp_rdata;
  logic                      map_write, map_enable;
  logic [1:0]                map_index;
  logic [XLEN-PAGE_BITS-1:0] map_ppn;

  lsu_top #(.MAP_ENTRIES(MAP_ENTRIES), .MEM_WORDS(MEM_WORDS)) DUT (
    .clock, .reset, .req_ready, .req_valid, .req_op, .req_addr, .req_wdata,
    .resp_ready, .resp_valid, .resp_rdata, .resp_fault,
    .map_write, .map_index, .map_ppn, .map_enable
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Shadow state and expected results
  logic [7:0]                shadow_mem [MEM_BYTES];
  logic                      shadow_valid [MAP_ENTRIES];
  logic [XLEN-PAGE_BITS-1:0] shadow_ppn [MAP_ENTRIES];
  logic                      exp_fault [$];
  logic                      exp_check [$];
  logic [XLEN-1:0]           exp_data [$];
  string                     exp_name [$];
  logic [XLEN-1:0]           word_addrs [$];

  logic [31:0] lfsr_state = 32'h3123_e8dd;
  string       test_name = "reset";
  int          errors = 0;
  int          errors_at_start, tests_passed, tests_failed;
  logic        e_fault, e_check;
  logic [31:0] e_data;
  string       e_name;

  // ####################################################################
  // Checks
  // ####################################################################

  always @(posedge clock) begin
    if (!reset && resp_valid && resp_ready) begin
      if (exp_fault.size() == 0) begin
        errors++;
        $display("A response arrived with no request outstanding during %s", test_name);
      end else begin
        e_fault = exp_fault.pop_front();
        e_check = exp_check.pop_front();
        e_data  = exp_data.pop_front();
        e_name  = exp_name.pop_front();
        response_matches: assert (resp_fault == e_fault && (!e_check || resp_rdata == e_data))
          else begin
            errors++;
            $display("[ERROR] %s expected fault %0b data %h, actual fault %0b data %h",
                     e_name, e_fault, e_data, resp_fault, resp_rdata);
          end
      end
    end
  end

  held_result_stable: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_fault))
    else begin
      errors++;
      $display("The held result changed under back-pressure during %s", test_name);
    end

  held_blocks_request: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |-> !req_ready)
    else begin
      errors++;
      $display("req_ready was high while a result was held during %s", test_name);
    end

  // ####################################################################
  // Helpers
  // ####################################################################

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic mem_op_t make_op(logic load, logic sgn, access_size_t size);
    mem_op_t op;
    op.is_load   = load;
    op.is_signed = sgn;
    op.size      = size;
    return op;
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s during %s", what, test_name);
    $display("TEST FAILED");
    $finish;
  endtask

  // Expected value from the shadow, then drive the request
  task automatic start_req(input mem_op_t op, input logic [31:0] va, input logic [31:0] wd);
    logic [1:0]  idx;
    logic [31:0] pa_full, value;
    int          pa, nbytes;
    idx     = va[PAGE_BITS +: 2];
    nbytes  = (op.size == SIZE_BYTE) ? 1 : (op.size == SIZE_HALF) ? 2 : 4;
    pa_full = {shadow_ppn[idx], va[PAGE_BITS-1:0]};
    pa      = int'(pa_full % MEM_BYTES);
    value   = '0;
    if (shadow_valid[idx] && op.is_load) begin
      for (int i = 0; i < nbytes; i++) value[8*i +: 8] = shadow_mem[pa + i];
      if (op.is_signed && value[8*nbytes-1]) value = value | (32'hffff_ffff << (8*nbytes));
    end else if (shadow_valid[idx]) begin
      for (int i = 0; i < nbytes; i++) shadow_mem[pa + i] = wd[8*i +: 8];
    end
    exp_fault.push_back(!shadow_valid[idx]);
    exp_check.push_back(op.is_load && shadow_valid[idx]);
    exp_data.push_back(value);
    exp_name.push_back(test_name);
    @(negedge clock);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = va;
    req_wdata = wd;
  endtask

  task automatic wait_accept;
    int n;
    n = 0;
    @(posedge clock);
    while (!req_ready) begin
      n++;
      if (n == TIMEOUT) stop_on_timeout("request acceptance");
      @(posedge clock);
    end
  endtask

  task automatic wait_resp;
    int n;
    n = 0;
    @(posedge clock);
    while (!resp_valid) begin
      n++;
      if (n == TIMEOUT) stop_on_timeout("a response");
      @(posedge clock);
    end
  endtask

  task automatic wait_idle;
    int n;
    n = 0;
    @(negedge clock);
    req_valid = 1'b0;
    while (exp_fault.size() != 0) begin
      n++;
      if (n == TIMEOUT) stop_on_timeout("outstanding responses");
      @(negedge clock);
    end
  endtask

  task automatic send(input mem_op_t op, input logic [31:0] va, input logic [31:0] wd);
    start_req(op, va, wd);
    wait_accept();
  endtask

  task automatic set_map(input logic [1:0] idx, input logic [19:0] ppn, input logic en);
    wait_idle();
    map_write  = 1'b1;
    map_index  = idx;
    map_ppn    = ppn;
    map_enable = en;
    @(negedge clock);
    map_write = 1'b0;
    shadow_valid[idx] = en;
    shadow_ppn[idx]   = ppn;
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test;
    wait_idle();
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed", test_name);
    end
  endtask

  // ####################################################################
  // Stimulus
  // ####################################################################

  initial begin
    logic [31:0] r, d, va;
    reset      = 1'b1;
    req_valid  = 1'b0;
    req_op     = '0;
    req_addr   = '0;
    req_wdata  = '0;
    resp_ready = 1'b1;
    map_write  = 1'b0;
    map_index  = '0;
    map_ppn    = '0;
    map_enable = 1'b0;
    for (int i = 0; i < MAP_ENTRIES; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_ppn[i]   = '0;
    end
    repeat (3) @(negedge clock);
    reset = 1'b0;

    begin_test("word_round_trip");
    random_bits(20, r);
    set_map(2'd0, r[19:0], 1'b1);
    for (int i = 0; i < 8; i++) begin
      random_bits(10, r);
      random_bits(32, d);
      va = {20'h0, r[9:0], 2'b00};
      word_addrs.push_back(va);
      send(make_op(0, 0, SIZE_WORD), va, d);
    end
    foreach (word_addrs[i]) send(make_op(1, 0, SIZE_WORD), word_addrs[i], '0);
    end_test();

    begin_test("sub_word_access");
    for (int off = 0; off < 4; off++) begin
      random_bits(10, r);
      va = {20'h0, r[9:0], 2'b00};
      random_bits(32, d);
      send(make_op(0, 0, SIZE_WORD), va, d);
      random_bits(8, d);
      d[7] = off[0];  // Both signs get covered
      send(make_op(0, 0, SIZE_BYTE), va + off, d);
      send(make_op(1, 0, SIZE_WORD), va, '0);
      send(make_op(1, 1, SIZE_BYTE), va + off, '0);
      send(make_op(1, 0, SIZE_BYTE), va + off, '0);
      if (off < 3) begin
        random_bits(16, d);
        d[15] = !off[0];
        send(make_op(0, 0, SIZE_HALF), va + off, d);
        send(make_op(1, 0, SIZE_WORD), va, '0);
        send(make_op(1, 1, SIZE_HALF), va + off, '0);
        send(make_op(1, 0, SIZE_HALF), va + off, '0);
      end
    end
    end_test();

    begin_test("translation_alias");
    set_map(2'd1, shadow_ppn[0], 1'b1);
    for (int i = 0; i < 4; i++) begin
      random_bits(10, r);
      va = {20'h0, r[9:0], 2'b00};
      random_bits(32, d);
      send(make_op(0, 0, SIZE_WORD), 32'h1000 | va, d);
      send(make_op(1, 0, SIZE_WORD), va, '0);
      random_bits(32, d);
      send(make_op(0, 0, SIZE_WORD), va, d);
      send(make_op(1, 0, SIZE_WORD), 32'h1000 | va, '0);
    end
    end_test();

    begin_test("unmapped_fault");
    va = word_addrs[0];
    random_bits(32, d);
    send(make_op(0, 0, SIZE_WORD), 32'h2000 | va, d);  // Entry 2 never mapped
    send(make_op(1, 0, SIZE_WORD), 32'h2000 | va, '0);
    send(make_op(1, 0, SIZE_WORD), va, '0);
    set_map(2'd1, shadow_ppn[0], 1'b0);
    send(make_op(0, 0, SIZE_BYTE), 32'h1000 | va, d);
    send(make_op(1, 0, SIZE_WORD), va, '0);
    end_test();

    begin_test("back_pressure");
    for (int k = 0; k < 4; k++) begin
      @(negedge clock);
      resp_ready = 1'b0;
      start_req(make_op(1, 0, SIZE_WORD), word_addrs[k], '0);
      wait_accept();
      start_req(make_op(1, 1, SIZE_BYTE), word_addrs[k+4] + k, '0);
      wait_resp();
      random_bits(3, r);
      repeat (r + 1) @(posedge clock);
      @(negedge clock);
      resp_ready = 1'b1;  // Next request is already waiting
      wait_accept();
      @(negedge clock);
      resp_ready = 1'b0;
      req_valid  = 1'b0;
      wait_resp();
      random_bits(3, r);
      repeat (r + 1) @(posedge clock);
      @(negedge clock);
      resp_ready = 1'b1;
      wait_idle();
    end
    end_test();

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
